/* hw/sdram_params.svh */
// Timing, slot schedule, mode register and width constants, included by RTL and testbench
`ifndef SDRAM_PARAMS_SVH
`define SDRAM_PARAMS_SVH

// bus widths
`define SD_DQ_W 16
`define SD_A_W  13

// ----------------------------------------------------------------------
// slot schedule, one round is 12 states
// ----------------------------------------------------------------------
`define SD_SLOT_LAST 4'd11

`define SD_RAS0  4'd0   // slot 0 ACTIVE
`define SD_CAS0  4'd3   // slot 0 READ/WRITE, auto precharge
`define SD_READ0 4'd8   // slot 0 word registered from DQ
`define SD_DS0   4'd4   // slot 0 dqm open here and in the next state

`define SD_RAS1  4'd4   // slot 1 ACTIVE or AUTO_REFRESH
`define SD_CAS1  4'd7
`define SD_READ1 4'd0   // first burst word, next round
`define SD_DS1   4'd8   // slot 1 dqm open up to the end of the round

// burst 4, sequential, CL3, standard mode, single write bursts
`define SD_MODE {3'b000, 1'b1, 2'b00, 3'd3, 1'b0, 3'b010}

// 64 ms / 8192 rows = 7.8 us
`define SD_MHZ          80
`define SD_RFRSH_CYCLES (78 * `SD_MHZ / 10)

`define SD_INIT_ROUNDS 5'd31   // power-up countdown

`endif

/* hw/sdram_pkg.sv */
// Command, port select and address types shared by the SDRAM controller and its testbench
`include "sdram_params.svh"

package sdram_pkg;

	// bit order nCS, nRAS, nCAS, nWE
	typedef enum logic [3:0] {
		INHIBIT      = 4'b1111,
		NOP          = 4'b0111,
		ACTIVE       = 4'b0011,
		READ         = 4'b0101,
		WRITE        = 4'b0100,
		PRECHARGE    = 4'b0010,
		AUTO_REFRESH = 4'b0001,
		LOAD_MODE    = 4'b0000
	} sd_cmd_t;

	// owner of a slot, slot 0 uses REQ and ROM, slot 1 uses REQ and SP
	typedef enum logic [1:0] {
		NONE = 2'd0,
		REQ  = 2'd1,
		ROM  = 2'd2,
		SP   = 2'd3
	} port_sel_t;

	typedef logic [`SD_DQ_W-1:0] word_t;

	// word address, 8 MiB regions in the top bits
	typedef logic [25:1] addr_t;

	typedef logic [3:0] slot_t;

endpackage

/* hw/sdram_sequencer.sv */
// Slot counter, power-up countdown and refresh interval timer for the SDRAM controller
`timescale 1ns/1ps
`include "sdram_params.svh"

module sdram_sequencer (
	input  logic             clk,
	input  logic             init_n,
	output sdram_pkg::slot_t t,
	output logic             init,
	output logic [4:0]       init_count,
	output logic             need_refresh,
	input  logic             refresh_taken
);
	localparam int RC_W = $clog2(`SD_RFRSH_CYCLES + 1);

	logic [RC_W-1:0] rfsh_cnt;   // cycles since last refresh

	assign need_refresh = rfsh_cnt >= RC_W'(`SD_RFRSH_CYCLES);

	// ----------------------------------------------------------------------
	// slot counter, free running
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			t <= `SD_RAS0;
		end else begin
			t <= (t == `SD_SLOT_LAST) ? `SD_RAS0 : t + 4'd1;
		end
	end

	// power-up, one count per round
	always_ff @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			init_count <= `SD_INIT_ROUNDS;
			init <= 1'b1;
		end else begin
			if (t == `SD_SLOT_LAST && init_count != 5'd0)
				init_count <= init_count - 5'd1;
			init <= init_count != 5'd0;
		end
	end

	// refresh interval, holds once due
	always_ff @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			rfsh_cnt <= '0;
		end else if (refresh_taken && t == `SD_RAS1) begin
			rfsh_cnt <= '0;   // auto refresh goes out now
		end else if (!need_refresh) begin
			rfsh_cnt <= rfsh_cnt + 1'b1;
		end
	end

	// counter never leaves the round
	a_slot_wrap: assert property (@(posedge clk) disable iff (!init_n)
		t <= `SD_SLOT_LAST);

endmodule

/* hw/sdram_arbiter.sv */
// Per-slot requester selection for the SDRAM controller, holds one access per slot for a round
`timescale 1ns/1ps
`include "sdram_params.svh"

module sdram_arbiter (
	input  logic                 clk,
	input  logic                 init_n,
	input  sdram_pkg::slot_t     t,
	input  logic                 init,
	input  logic                 need_refresh,
	output logic                 refresh_taken,
	// port 1 and cpu rom, bank 3
	input  logic                 port1_req,
	input  logic                 port1_we,
	input  sdram_pkg::addr_t     port1_a,
	input  logic [1:0]           port1_ds,
	input  sdram_pkg::word_t     port1_d,
	input  sdram_pkg::addr_t     rom_addr,
	input  logic                 rom_cs,
	input  logic                 rom_valid,
	// port 2 and sprites, banks 0 to 2
	input  logic                 port2_req,
	input  logic                 port2_we,
	input  sdram_pkg::addr_t     port2_a,
	input  logic [1:0]           port2_ds,
	input  sdram_pkg::word_t     port2_d,
	input  logic                 sp_req,
	input  sdram_pkg::addr_t     sp_addr,
	// slot 0 access
	output sdram_pkg::port_sel_t sel0,
	output sdram_pkg::addr_t     addr0,
	output logic [1:0]           ds0,
	output sdram_pkg::word_t     din0,
	output logic                 oe0,
	output logic                 we0,
	// slot 1 access
	output sdram_pkg::port_sel_t sel1,
	output sdram_pkg::addr_t     addr1,
	output logic [1:0]           ds1,
	output sdram_pkg::word_t     din1,
	output logic                 oe1,
	output logic                 we1
);
	import sdram_pkg::*;

	// picked one state early so the choice holds from the ACTIVE state on
	localparam slot_t PICK0 = (`SD_RAS0 + `SD_SLOT_LAST) % (`SD_SLOT_LAST + 4'd1);
	localparam slot_t PICK1 = `SD_RAS1 - 4'd1;

	port_sel_t sel0_n, sel1_n;
	addr_t     addr0_n, addr1_n;
	logic [1:0] ds0_n, ds1_n;
	word_t     din0_n, din1_n;
	logic      oe0_n, we0_n, oe1_n, we1_n;
	logic      port1_state, port2_state, sp_state;   // toggle flags
	logic      pick0, pick1;

	assign pick0 = !init && t == PICK0;
	assign pick1 = !init && t == PICK1;

	// slot 0, port 1 first, then rom
	always_comb begin
		sel0_n = NONE;
		addr0_n = addr0;
		addr0_n[25:24] = 2'd3;
		ds0_n = 2'b00;
		din0_n = '0;
		oe0_n = 1'b0;
		we0_n = 1'b0;
		if (!refresh_taken) begin   // no bank 3 access in a refresh round
			if (port1_req != port1_state) begin
				sel0_n = REQ;
				addr0_n[23:1] = port1_a[23:1];
				ds0_n = port1_ds;
				din0_n = port1_d;
				oe0_n = !port1_we;
				we0_n = port1_we;
			end else if (rom_cs && !rom_valid) begin
				sel0_n = ROM;
				addr0_n[23:1] = rom_addr[23:1];
				ds0_n = 2'b11;
				oe0_n = 1'b1;
			end
		end
	end

	// slot 1, port 2 first, then sprites
	always_comb begin
		sel1_n = NONE;
		addr1_n = addr1;
		ds1_n = 2'b00;
		din1_n = '0;
		oe1_n = 1'b0;
		we1_n = 1'b0;
		if (port2_req != port2_state) begin
			sel1_n = REQ;
			addr1_n = port2_a;
			ds1_n = port2_ds;
			din1_n = port2_d;
			oe1_n = !port2_we;
			we1_n = port2_we;
		end else if (sp_req != sp_state) begin
			sel1_n = SP;
			addr1_n = {sp_addr[25:3], 2'b00};   // burst aligned
			ds1_n = 2'b11;
			oe1_n = 1'b1;
		end
	end

	// ----------------------------------------------------------------------
	// grants and toggle flags
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			sel0 <= NONE;
			sel1 <= NONE;
			{oe0, we0, oe1, we1} <= 4'b0000;
			port1_state <= 1'b0;
			port2_state <= 1'b0;
			sp_state <= 1'b0;
			refresh_taken <= 1'b0;
		end else begin
			if (pick0) begin
				sel0 <= sel0_n;
				oe0 <= oe0_n;
				we0 <= we0_n;
				if (sel0_n == REQ)
					port1_state <= port1_req;
			end
			if (pick1) begin
				sel1 <= sel1_n;
				oe1 <= oe1_n;
				we1 <= we1_n;
				// refresh only with both slots idle
				refresh_taken <= sel1_n == NONE && need_refresh && !oe0 && !we0;
				case (sel1_n)
					REQ: port2_state <= port2_req;
					SP: sp_state <= sp_req;
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pick0) begin
			addr0 <= addr0_n;
			ds0 <= ds0_n;
			din0 <= din0_n;
		end
		if (pick1) begin
			addr1 <= addr1_n;
			ds1 <= ds1_n;
			din1 <= din1_n;
		end
	end

	// nothing is granted before the chip is set up
	a_no_grant_in_init: assert property (@(posedge clk) disable iff (!init_n)
		init |-> (sel0 == NONE && sel1 == NONE && !refresh_taken));

endmodule

/* hw/sdram_cmd_gen.sv */
// SDRAM command, address and data bus driver, follows the slot schedule and returns bank 3 data
`timescale 1ns/1ps
`include "sdram_params.svh"

module sdram_cmd_gen (
	input  logic                 clk,
	input  logic                 init_n,
	input  sdram_pkg::slot_t     t,
	input  logic                 init,
	input  logic [4:0]           init_count,
	input  sdram_pkg::port_sel_t sel0,
	input  sdram_pkg::addr_t     addr0,
	input  logic [1:0]           ds0,
	input  sdram_pkg::word_t     din0,
	input  logic                 oe0,
	input  logic                 we0,
	input  sdram_pkg::port_sel_t sel1,
	input  sdram_pkg::addr_t     addr1,
	input  logic [1:0]           ds1,
	input  sdram_pkg::word_t     din1,
	input  logic                 oe1,
	input  logic                 we1,
	input  logic                 refresh_taken,
	// chip pins
	inout  wire sdram_pkg::word_t sdram_dq,
	output logic [`SD_A_W-1:0]   sdram_a,
	output logic [1:0]           sdram_ba,
	output logic                 sdram_dqml,
	output logic                 sdram_dqmh,
	output logic                 sdram_ncs,
	output logic                 sdram_nras,
	output logic                 sdram_ncas,
	output logic                 sdram_nwe,
	// bank 3 results
	input  logic                 port1_req,
	output logic                 port1_ack,
	output sdram_pkg::word_t     port1_q,
	input  logic                 rom_cs,
	output sdram_pkg::word_t     rom_q,
	output logic                 rom_valid,
	// to the slot 1 collectors
	output logic                 start1,
	output logic                 wdone1,
	output sdram_pkg::word_t     sd_din
);
	import sdram_pkg::*;

	sd_cmd_t    sd_cmd;
	word_t      dq_out;
	logic       dq_oe;
	logic       bank1_hi;   // regions 3 to 5
	logic [1:0] bank1;

	assign {sdram_ncs, sdram_nras, sdram_ncas, sdram_nwe} = sd_cmd;
	assign sdram_dq = dq_oe ? dq_out : 'z;

	// six 8 MiB regions onto banks 0,1,2,0,1,2
	assign bank1_hi = addr1[25:23] > 3'd2;
	assign bank1 = bank1_hi ? addr1[24:23] + 2'd1 : addr1[24:23];

	assign start1 = t == `SD_READ1 && oe1;
	assign wdone1 = t == `SD_CAS1 && we1;

	// ----------------------------------------------------------------------
	// commands, address and dqm
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			sd_cmd <= NOP;
			sdram_a <= '0;
			sdram_ba <= 2'b00;
			{sdram_dqmh, sdram_dqml} <= 2'b11;
			dq_oe <= 1'b0;
			port1_ack <= 1'b0;
			rom_valid <= 1'b0;
		end else begin
			sd_cmd <= NOP;
			{sdram_dqmh, sdram_dqml} <= 2'b11;
			dq_oe <= 1'b0;
			if (init) begin
				if (t == `SD_RAS0) begin
					case (init_count)
						5'd15: begin
							sd_cmd <= PRECHARGE;
							sdram_a[10] <= 1'b1;   // all banks
						end
						5'd10, 5'd8: sd_cmd <= AUTO_REFRESH;
						5'd2: begin
							sd_cmd <= LOAD_MODE;
							sdram_a <= `SD_MODE;
							sdram_ba <= 2'b00;
						end
						default: ;
					endcase
				end
			end else begin
				if (!rom_cs)
					rom_valid <= 1'b0;

				if (t == `SD_RAS0 && sel0 != NONE) begin
					sd_cmd <= ACTIVE;
					sdram_a <= addr0[22:10];
					sdram_ba <= addr0[25:24];
				end
				if (t == `SD_RAS1) begin
					if (sel1 != NONE) begin
						sd_cmd <= ACTIVE;
						sdram_a <= addr1[22:10];
						sdram_ba <= bank1;
					end else if (refresh_taken) begin
						sd_cmd <= AUTO_REFRESH;
					end
				end

				// column phase, A10 set for auto precharge
				if (t == `SD_CAS0 && (oe0 || we0)) begin
					sd_cmd <= we0 ? WRITE : READ;
					sdram_a <= {2'b00, 1'b1, addr0[23], addr0[9:1]};
					sdram_ba <= addr0[25:24];
					if (we0) begin
						{sdram_dqmh, sdram_dqml} <= ~ds0;
						dq_oe <= 1'b1;
						if (sel0 == REQ)
							port1_ack <= port1_req;   // write done
					end
				end
				if (t == `SD_CAS1 && (oe1 || we1)) begin
					sd_cmd <= we1 ? WRITE : READ;
					sdram_a <= {2'b00, 1'b1, bank1_hi, addr1[9:1]};
					sdram_ba <= bank1;
					if (we1) begin
						{sdram_dqmh, sdram_dqml} <= ~ds1;
						dq_oe <= 1'b1;
					end
				end

				// read windows, slot 0 word masked at t=5 if slot 1 writes
				if (t == `SD_DS0 && oe0)
					{sdram_dqmh, sdram_dqml} <= 2'b00;
				if (t == `SD_DS0 + 4'd1 && oe0 && !we1)
					{sdram_dqmh, sdram_dqml} <= 2'b00;
				if (t >= `SD_DS1 && oe1)
					{sdram_dqmh, sdram_dqml} <= 2'b00;

				if (t == `SD_READ0 && oe0) begin
					if (sel0 == REQ)
						port1_ack <= port1_req;
					if (sel0 == ROM)
						rom_valid <= 1'b1;
				end
			end
		end
	end

	// data path
	always_ff @(posedge clk) begin
		sd_din <= sdram_dq;   // every cycle
		if (t == `SD_CAS0 && we0)
			dq_out <= din0;
		if (t == `SD_CAS1 && we1)
			dq_out <= din1;
		if (t == `SD_READ0 && oe0) begin
			if (sel0 == REQ)
				port1_q <= sd_din;
			if (sel0 == ROM)
				rom_q <= sd_din;
		end
	end

	// DQ only driven while a WRITE is on the pins
	a_dq_write_only: assert property (@(posedge clk) disable iff (!init_n)
		dq_oe |-> sd_cmd == WRITE);

endmodule

/* hw/sdram_burst_collect.sv */
// Slot 1 burst collector, packs consecutive read words into one payload and acknowledges it
`timescale 1ns/1ps
`include "sdram_params.svh"

module sdram_burst_collect #(
	parameter type data_t = logic [31:0]
) (
	input  logic             clk,
	input  logic             init_n,
	input  logic             req,
	input  logic             start,
	input  logic             sel_me,
	input  sdram_pkg::word_t sd_din,
	input  logic             wdone,
	output data_t            q,
	output logic             ack
);
	localparam int WORDS = $bits(data_t) / `SD_DQ_W;
	localparam int CNT_W = $clog2(WORDS);

	logic [CNT_W-1:0] cnt;   // words taken so far
	logic             busy;
	logic             last;

	assign last = busy && cnt == CNT_W'(WORDS - 1);

	always_ff @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			busy <= 1'b0;
			cnt <= '0;
			ack <= 1'b0;
		end else begin
			if (start && sel_me) begin
				busy <= 1'b1;
				cnt <= CNT_W'(1);
			end else if (last) begin
				busy <= 1'b0;
			end else if (busy) begin
				cnt <= cnt + 1'b1;
			end
			if (last || (wdone && sel_me))
				ack <= req;
		end
	end

	// low word first, shifted down from the top
	always_ff @(posedge clk) begin
		if ((start && sel_me) || busy)
			q <= {sd_din, q[$bits(data_t)-1:`SD_DQ_W]};
	end

endmodule

/* hw/sdram_ctrl.sv */
// Two-slot SDRAM controller top, bank 3 single words and banks 0 to 2 four-word bursts
`timescale 1ns/1ps
`include "sdram_params.svh"

module sdram_ctrl (
	input  logic             clk,
	input  logic             init_n,
	// chip pins
	inout  wire sdram_pkg::word_t sdram_dq,
	output logic [`SD_A_W-1:0] sdram_a,
	output logic [1:0]       sdram_ba,
	output logic             sdram_dqml,
	output logic             sdram_dqmh,
	output logic             sdram_ncs,
	output logic             sdram_nras,
	output logic             sdram_ncas,
	output logic             sdram_nwe,
	// port 1, bank 3
	input  logic             port1_req,
	output logic             port1_ack,
	input  logic             port1_we,
	input  sdram_pkg::addr_t port1_a,
	input  logic [1:0]       port1_ds,
	input  sdram_pkg::word_t port1_d,
	output sdram_pkg::word_t port1_q,
	// cpu rom, bank 3
	input  sdram_pkg::addr_t rom_addr,
	input  logic             rom_cs,
	output sdram_pkg::word_t rom_q,
	output logic             rom_valid,
	// port 2, banks 0 to 2
	input  logic             port2_req,
	output logic             port2_ack,
	input  logic             port2_we,
	input  sdram_pkg::addr_t port2_a,
	input  logic [1:0]       port2_ds,
	input  sdram_pkg::word_t port2_d,
	output logic [31:0]      port2_q,
	// sprites, banks 0 to 2
	input  logic             sp_req,
	output logic             sp_ack,
	input  sdram_pkg::addr_t sp_addr,
	output logic [63:0]      sp_q
);
	import sdram_pkg::*;

	slot_t      t;
	logic       init;
	logic [4:0] init_count;
	logic       need_refresh;
	logic       refresh_taken;
	port_sel_t  sel0, sel1;
	addr_t      addr0, addr1;
	logic [1:0] ds0, ds1;
	word_t      din0, din1;
	logic       oe0, we0, oe1, we1;
	logic       start1;
	logic       wdone1;
	word_t      sd_din;

	sdram_sequencer u_seq (
		.clk(clk), .init_n(init_n), .t(t), .init(init), .init_count(init_count),
		.need_refresh(need_refresh), .refresh_taken(refresh_taken)
	);

	sdram_arbiter u_arb (
		.clk(clk), .init_n(init_n), .t(t), .init(init),
		.need_refresh(need_refresh), .refresh_taken(refresh_taken),
		.port1_req(port1_req), .port1_we(port1_we), .port1_a(port1_a),
		.port1_ds(port1_ds), .port1_d(port1_d),
		.rom_addr(rom_addr), .rom_cs(rom_cs), .rom_valid(rom_valid),
		.port2_req(port2_req), .port2_we(port2_we), .port2_a(port2_a),
		.port2_ds(port2_ds), .port2_d(port2_d),
		.sp_req(sp_req), .sp_addr(sp_addr),
		.sel0(sel0), .addr0(addr0), .ds0(ds0), .din0(din0), .oe0(oe0), .we0(we0),
		.sel1(sel1), .addr1(addr1), .ds1(ds1), .din1(din1), .oe1(oe1), .we1(we1)
	);

	sdram_cmd_gen u_cmd (
		.clk(clk), .init_n(init_n), .t(t), .init(init), .init_count(init_count),
		.sel0(sel0), .addr0(addr0), .ds0(ds0), .din0(din0), .oe0(oe0), .we0(we0),
		.sel1(sel1), .addr1(addr1), .ds1(ds1), .din1(din1), .oe1(oe1), .we1(we1),
		.refresh_taken(refresh_taken),
		.sdram_dq(sdram_dq), .sdram_a(sdram_a), .sdram_ba(sdram_ba),
		.sdram_dqml(sdram_dqml), .sdram_dqmh(sdram_dqmh),
		.sdram_ncs(sdram_ncs), .sdram_nras(sdram_nras),
		.sdram_ncas(sdram_ncas), .sdram_nwe(sdram_nwe),
		.port1_req(port1_req), .port1_ack(port1_ack), .port1_q(port1_q),
		.rom_cs(rom_cs), .rom_q(rom_q), .rom_valid(rom_valid),
		.start1(start1), .wdone1(wdone1), .sd_din(sd_din)
	);

	// two words for port 2
	sdram_burst_collect #(.data_t(logic [31:0])) u_port2_col (
		.clk(clk), .init_n(init_n), .req(port2_req), .start(start1),
		.sel_me(sel1 == REQ), .sd_din(sd_din), .wdone(wdone1),
		.q(port2_q), .ack(port2_ack)
	);

	// full burst for sprites
	sdram_burst_collect #(.data_t(logic [63:0])) u_sp_col (
		.clk(clk), .init_n(init_n), .req(sp_req), .start(start1),
		.sel_me(sel1 == SP), .sd_din(sd_din), .wdone(wdone1),
		.q(sp_q), .ack(sp_ack)
	);

endmodule

/* tests/tb_clock.sv */
// Testbench clock and reset source for the SDRAM controller, 8 ns period, reset held 5 cycles
`timescale 1ns/1ps

module tb_clock #(
	parameter int RESET_CYCLES = 5
) (
	output logic clk,
	output logic init_n
);
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// release on a falling edge, away from the DUT's sampling edge
	initial begin
		init_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		init_n = 1'b1;
	end

endmodule

/* tests/sdram_chip_model.sv */
// Behavioral SDRAM for the controller testbench, 4 banks, CL3, burst 4 reads, single masked writes
`timescale 1ns/1ps

module sdram_chip_model (
	input  logic        clk,
	inout  wire  [15:0] dq,
	input  logic [12:0] a,
	input  logic [1:0]  ba,
	input  logic        dqml,
	input  logic        dqmh,
	input  logic        ncs,
	input  logic        nras,
	input  logic        ncas,
	input  logic        nwe
);
	import sdram_pkg::*;

	logic [15:0] mem [logic [24:0]];   // bank, row, col
	logic [12:0] open_row [4];
	logic [24:0] rd_key [6];           // read pipe, entry 0 on the pins
	logic [5:0]  rd_v = '0;
	logic [1:0]  dqm_d1 = 2'b11;
	logic [1:0]  dqm_d2 = 2'b11;       // read dqm latency 2
	logic [15:0] rd_word;
	sd_cmd_t     cmd;

	// contents of a cell never written, must match the testbench copy
	function automatic logic [15:0] fill(input logic [24:0] p);
		return p[15:0] ^ {p[24:16], p[24:18]} ^ 16'hc3a5;
	endfunction

	assign cmd = sd_cmd_t'({ncs, nras, ncas, nwe});
	assign rd_word = mem.exists(rd_key[0]) ? mem[rd_key[0]] : fill(rd_key[0]);
	assign dq = (rd_v[0] && dqm_d2 != 2'b11) ? rd_word : 16'hzzzz;

	always @(posedge clk) begin : chip
		logic [24:0] key;
		logic [9:0]  col;
		logic [15:0] cur;

		for (int i = 0; i < 5; i++)
			rd_key[i] <= rd_key[i + 1];
		rd_v <= {1'b0, rd_v[5:1]};
		dqm_d1 <= {dqmh, dqml};
		dqm_d2 <= dqm_d1;
		col = a[9:0];
		key = {ba, open_row[ba], col};

		case (cmd)
			ACTIVE: open_row[ba] <= a;
			READ: begin
				// sequential burst wraps inside 4 columns
				for (int i = 0; i < 4; i++) begin
					rd_v[2 + i] <= 1'b1;
					rd_key[2 + i] <= {ba, open_row[ba], col[9:2], col[1:0] + 2'(i)};
				end
			end
			WRITE: begin
				rd_v <= '0;   // write cuts a running burst
				cur = mem.exists(key) ? mem[key] : fill(key);
				if (!dqml)
					cur[7:0] = dq[7:0];
				if (!dqmh)
					cur[15:8] = dq[15:8];
				mem[key] = cur;
			end
			default: ;
		endcase
	end

endmodule

/* tests/tb_sdram_ctrl.sv */
// Random testbench for the SDRAM controller, checks all four ports against a reference memory
`timescale 1ns/1ps
`include "sdram_params.svh"

module tb_sdram_ctrl;
	import sdram_pkg::*;

	localparam int N_TRANS = 78;
	localparam int N_IDLE = 3;
	localparam int IDLE_CYCLES = N_IDLE * `SD_RFRSH_CYCLES;
	localparam int LIMIT = 12 * (N_TRANS * 4 + `SD_INIT_ROUNDS + 10) + IDLE_CYCLES;

	logic              clk;
	logic              init_n;
	wire  [15:0]       sdram_dq;
	logic [`SD_A_W-1:0] sdram_a;
	logic [1:0]        sdram_ba;
	logic              sdram_dqml, sdram_dqmh;
	logic              sdram_ncs, sdram_nras, sdram_ncas, sdram_nwe;
	logic              port1_req, port1_ack, port1_we;
	addr_t             port1_a;
	logic [1:0]        port1_ds;
	word_t             port1_d, port1_q;
	addr_t             rom_addr;
	logic              rom_cs, rom_valid;
	word_t             rom_q;
	logic              port2_req, port2_ack, port2_we;
	addr_t             port2_a;
	logic [1:0]        port2_ds;
	word_t             port2_d;
	logic [31:0]       port2_q;
	logic              sp_req, sp_ack;
	addr_t             sp_addr;
	logic [63:0]       sp_q;

	word_t       ref_mem [addr_t];
	addr_t       p1_addrs [$];
	logic [31:0] lcg_state = 32'd70238;
	int          n_checks = 0;
	int          n_err = 0;
	int          mon_err = 0;
	int          cycles = 0;
	int          n_boot = 0;
	int          n_refresh = 0;
	int          since_b3 = 1000;
	logic        count_refresh = 1'b0;
	sd_cmd_t     boot_cmd [4];
	logic [12:0] boot_a [4];

	tb_clock #(.RESET_CYCLES(5)) clkgen (.clk(clk), .init_n(init_n));

	sdram_ctrl uut (
		.clk(clk), .init_n(init_n),
		.sdram_dq(sdram_dq), .sdram_a(sdram_a), .sdram_ba(sdram_ba),
		.sdram_dqml(sdram_dqml), .sdram_dqmh(sdram_dqmh), .sdram_ncs(sdram_ncs),
		.sdram_nras(sdram_nras), .sdram_ncas(sdram_ncas), .sdram_nwe(sdram_nwe),
		.port1_req(port1_req), .port1_ack(port1_ack), .port1_we(port1_we),
		.port1_a(port1_a), .port1_ds(port1_ds), .port1_d(port1_d), .port1_q(port1_q),
		.rom_addr(rom_addr), .rom_cs(rom_cs), .rom_q(rom_q), .rom_valid(rom_valid),
		.port2_req(port2_req), .port2_ack(port2_ack), .port2_we(port2_we),
		.port2_a(port2_a), .port2_ds(port2_ds), .port2_d(port2_d), .port2_q(port2_q),
		.sp_req(sp_req), .sp_ack(sp_ack), .sp_addr(sp_addr), .sp_q(sp_q)
	);

	sdram_chip_model chip (
		.clk(clk), .dq(sdram_dq), .a(sdram_a), .ba(sdram_ba),
		.dqml(sdram_dqml), .dqmh(sdram_dqmh), .ncs(sdram_ncs),
		.nras(sdram_nras), .ncas(sdram_ncas), .nwe(sdram_nwe)
	);

	// ----------------------------------------------------------------------
	// random numbers and the memory model
	// ----------------------------------------------------------------------
	function automatic logic [15:0] rand16();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:16];
	endfunction

	function automatic logic [31:0] rand32();
		logic [15:0] hi;
		hi = rand16();
		return {hi, rand16()};
	endfunction

	// bank 3 direct, regions 0..5 folded onto banks 0,1,2,0,1,2 with col bit 9
	function automatic logic [24:0] phys_loc(input addr_t x);
		logic [2:0] r;
		r = x[25:23];
		if (x[25:24] == 2'd3)
			return {2'd3, x[22:10], x[23], x[9:1]};
		return {2'(r % 3), x[22:10], r >= 3'd3, x[9:1]};
	endfunction

	function automatic word_t fill(input logic [24:0] p);
		return p[15:0] ^ {p[24:16], p[24:18]} ^ 16'hc3a5;
	endfunction

	function automatic word_t exp_word(input addr_t x);
		return ref_mem.exists(x) ? ref_mem[x] : fill(phys_loc(x));
	endfunction

	function automatic void merge_write(input addr_t x, input word_t d, input logic [1:0] ds);
		word_t cur;
		cur = exp_word(x);
		if (ds[0])
			cur[7:0] = d[7:0];
		if (ds[1])
			cur[15:8] = d[15:8];
		ref_mem[x] = cur;
	endfunction

	function automatic addr_t rand_slot1_addr(input logic even);
		logic [2:0]  region;
		logic [31:0] r;
		addr_t       x;
		region = 3'(rand16() % 6);
		r = rand32();
		x = {region, r[21:0]};
		if (even)
			x[1] = 1'b0;   // keeps the pair inside one burst
		return x;
	endfunction

	// ----------------------------------------------------------------------
	// compare tasks
	// ----------------------------------------------------------------------
	task automatic check_word(input word_t got, input word_t exp, input string what);
		n_checks++;
		if (got !== exp) begin
			n_err++;
			$display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_long(input logic [31:0] got, input logic [31:0] exp, input string what);
		n_checks++;
		if (got !== exp) begin
			n_err++;
			$display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_burst(input logic [63:0] got, input logic [63:0] exp, input string what);
		n_checks++;
		if (got !== exp) begin
			n_err++;
			$display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_cmd(input sd_cmd_t got, input sd_cmd_t exp, input string what);
		n_checks++;
		if (got !== exp) begin
			n_err++;
			$display("** Error at %0t: %s got %s expected %s", $time, what, got.name(),
				exp.name());
		end
	endtask

	// ----------------------------------------------------------------------
	// port transactions, driven on the falling edge
	// ----------------------------------------------------------------------
	task automatic port1_access(input addr_t x, input logic we, input word_t d,
		input logic [1:0] ds);
		@(negedge clk);
		port1_a = x;
		port1_we = we;
		port1_d = d;
		port1_ds = ds;
		port1_req = ~port1_req;
		do @(negedge clk); while (port1_ack != port1_req);
		if (we)
			merge_write(x, d, ds);
		else
			check_word(port1_q, exp_word(x), "port1 read");
	endtask

	task automatic rom_read(input addr_t x);
		@(negedge clk);
		rom_addr = x;
		rom_cs = 1'b1;
		do @(negedge clk); while (!rom_valid);
		check_word(rom_q, exp_word(x), "rom read");
		rom_cs = 1'b0;
		@(negedge clk);
		if (rom_valid) begin
			n_err++;
			$display("rom_valid stayed high a cycle after rom_cs went low, at %0t", $time);
		end
	endtask

	task automatic port2_access(input addr_t x, input logic we, input word_t d,
		input logic [1:0] ds);
		@(negedge clk);
		port2_a = x;
		port2_we = we;
		port2_d = d;
		port2_ds = ds;
		port2_req = ~port2_req;
		do @(negedge clk); while (port2_ack != port2_req);
		if (we)
			merge_write(x, d, ds);
		else
			check_long(port2_q, {exp_word(x + 1), exp_word(x)}, "port2 read");
	endtask

	task automatic sp_read(input addr_t x);
		addr_t b;
		b = {x[25:3], 2'b00};
		@(negedge clk);
		sp_addr = x;
		sp_req = ~sp_req;
		do @(negedge clk); while (sp_ack != sp_req);
		check_burst(sp_q, {exp_word(b + 3), exp_word(b + 2), exp_word(b + 1), exp_word(b)},
			"sprite burst");
	endtask

	task automatic port1_pair();
		logic [31:0] r;
		addr_t       x;
		r = rand32();
		x = {2'b11, r[22:0]};
		p1_addrs.push_back(x);
		port1_access(x, 1'b1, rand16(), r[31:30]);
		port1_access(x, 1'b0, '0, 2'b00);
	endtask

	task automatic check_power_up();
		if (n_boot < 4) begin
			n_err++;
			$display("power-up sequence incomplete, only %0d commands seen", n_boot);
		end else begin
			check_cmd(boot_cmd[0], PRECHARGE, "power-up command 0");
			check_word(word_t'(boot_a[0][10]), 16'd1, "precharge all A10");
			check_cmd(boot_cmd[1], AUTO_REFRESH, "power-up command 1");
			check_cmd(boot_cmd[2], AUTO_REFRESH, "power-up command 2");
			check_cmd(boot_cmd[3], LOAD_MODE, "power-up command 3");
			check_word(word_t'(boot_a[3]), word_t'(`SD_MODE), "mode register");
		end
	endtask

	// ----------------------------------------------------------------------
	// pin monitor, power-up order and refresh placement
	// ----------------------------------------------------------------------
	always @(negedge clk) begin : pins
		sd_cmd_t cmd;
		cmd = sd_cmd_t'({sdram_ncs, sdram_nras, sdram_ncas, sdram_nwe});
		if (init_n) begin
			if (since_b3 < 1000)
				since_b3++;
			if (n_boot < 4) begin
				if (cmd != NOP) begin
					boot_cmd[n_boot] = cmd;
					boot_a[n_boot] = sdram_a;
					n_boot++;
				end
			end else begin
				if (cmd == ACTIVE && sdram_ba == 2'd3)
					since_b3 = 0;
				if (cmd == AUTO_REFRESH) begin
					if (since_b3 < 12) begin
						mon_err++;
						$display("auto refresh during a bank 3 access at %0t", $time);
					end
					if (count_refresh)
						n_refresh++;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("timeout, run still busy after %0d cycles", cycles);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	initial begin
		addr_t       base;
		addr_t       x;
		logic [31:0] rnd;
		port1_req = 1'b0;
		port1_we = 1'b0;
		port1_a = '0;
		port1_ds = 2'b00;
		port1_d = '0;
		rom_addr = '0;
		rom_cs = 1'b0;
		port2_req = 1'b0;
		port2_we = 1'b0;
		port2_a = '0;
		port2_ds = 2'b00;
		port2_d = '0;
		sp_req = 1'b0;
		sp_addr = '0;
		@(posedge init_n);

		repeat (12) port1_pair();   // held off until power-up ends
		check_power_up();

		// rom, every other read from a port 1 address
		for (int i = 0; i < 10; i++) begin
			if (i % 2 == 0) begin
				rom_read(p1_addrs[i]);
			end else begin
				rnd = rand32();
				rom_read({2'b11, rnd[22:0]});
			end
		end

		// both slots busy together
		fork
			repeat (8) port1_pair();
			repeat (8) begin
				port2_access(rand_slot1_addr(1'b1), 1'b0, '0, 2'b00);
				sp_read(rand_slot1_addr(1'b0));
			end
		join

		// same offset in all six regions
		base = rand_slot1_addr(1'b1);
		for (int r = 0; r < 6; r++) begin
			x = {3'(r), base[22:1]};
			port2_access(x, 1'b1, rand16(), 2'b11);
		end
		for (int r = 0; r < 6; r++) begin
			x = {3'(r), base[22:1]};
			port2_access(x, 1'b0, '0, 2'b00);
		end

		// idle stretch, periodic refresh only
		@(negedge clk);
		count_refresh = 1'b1;
		repeat (IDLE_CYCLES) @(negedge clk);
		count_refresh = 1'b0;
		if (n_refresh < N_IDLE - 1) begin
			n_err++;
			$display("only %0d auto refreshes in the idle stretch", n_refresh);
		end

		n_err = n_err + mon_err;
		$display("checks %0d, errors %0d", n_checks, n_err);
		if (n_err == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* sources.f */
+incdir+hw
hw/sdram_pkg.sv
hw/sdram_sequencer.sv
hw/sdram_arbiter.sv
hw/sdram_cmd_gen.sv
hw/sdram_burst_collect.sv
hw/sdram_ctrl.sv
tests/tb_clock.sv
tests/sdram_chip_model.sv
tests/tb_sdram_ctrl.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_sdram_ctrl
FLIST     = sources.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
